// File: logic/game_if.sv
interface game_if;

    tug_pkg::phase_t phase;
    logic [6:0]      sec_set;
    logic [3:0]      win_target;
    logic [6:0]      sec_left;
    logic [1:0]      cd_left;      // start countdown, 3 down to 1
    logic [4:0]      round_no;
    logic [3:0]      score1;
    logic [3:0]      score2;

    modport src (
        output phase, sec_set, win_target, sec_left, cd_left,
        output round_no, score1, score2
    );

    modport sink (
        input phase, sec_set, win_target, sec_left, cd_left,
        input round_no, score1, score2
    );

endinterface

// File: logic/key_debounce.sv
module key_debounce #(
    parameter int debounce_cycles = 240_000
) (
    input  logic clk,
    input  logic rst,
    input  logic key,
    output logic key_pulse
);

    localparam int cnt_w = $clog2(debounce_cycles + 1);

    logic             key_q;
    logic             stable;
    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            key_q     <= 1'b0;
            stable    <= 1'b0;
            cnt       <= '0;
            key_pulse <= 1'b0;
        end
        else
        begin
            key_q     <= key;
            key_pulse <= 1'b0;
            if (key_q == stable)
                cnt <= '0;                             // bounce, start over
            else if (cnt == cnt_w'(debounce_cycles - 1))
            begin
                cnt       <= '0;
                stable    <= key_q;
                key_pulse <= key_q;                    // rising edge only
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: logic/match_ctrl.sv
module match_ctrl #(
    parameter int clk_per_sec = 12_000_000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       set_pulse,
    input  logic       refer_pulse,
    input  logic [6:0] sec_set,
    input  logic [3:0] win_target,
    rope_if.ctrl       rc,
    game_if.src        gs,
    output logic       round_led1,
    output logic       round_led2,
    output logic       match_led1,
    output logic       match_led2
);

    localparam int tick_w = (clk_per_sec > 1) ? $clog2(clk_per_sec) : 1;

    logic [tick_w-1:0] tick;
    logic              sec_tick;
    logic              scored;         // first cycle of check
    logic              target_hit;
    tug_pkg::winner_t  result;

    assign sec_tick   = (tick == tick_w'(clk_per_sec - 1));
    assign target_hit = (gs.score1 == win_target) || (gs.score2 == win_target);

    assign rc.active  = (gs.phase == tug_pkg::gaming);
    assign rc.time_up = rc.active && (gs.sec_left == 7'd0);

    assign gs.sec_set    = sec_set;
    assign gs.win_target = win_target;

    // one-second tick, runs only while counting
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            tick <= '0;
        else if ((gs.phase == tug_pkg::counting_down || gs.phase == tug_pkg::gaming)
                 && !sec_tick)
            tick <= tick + 1'b1;
        else
            tick <= '0;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            gs.phase    <= tug_pkg::init;
            gs.cd_left  <= 2'd0;
            gs.sec_left <= 7'd0;
            gs.round_no <= 5'd1;
            gs.score1   <= 4'd0;
            gs.score2   <= 4'd0;
            rc.start    <= 1'b0;
            scored      <= 1'b0;
            result      <= tug_pkg::none;
            round_led1  <= 1'b0;
            round_led2  <= 1'b0;
            match_led1  <= 1'b0;
            match_led2  <= 1'b0;
        end
        else
        begin
            rc.start <= 1'b0;
            scored   <= 1'b0;
            case (gs.phase)
                tug_pkg::init:
                    gs.phase <= tug_pkg::time_set;
                tug_pkg::time_set:
                    if (set_pulse)
                        gs.phase <= tug_pkg::round_set;
                tug_pkg::round_set:
                    if (set_pulse)
                        gs.phase <= tug_pkg::ready;
                tug_pkg::ready:
                    if (refer_pulse)
                    begin
                        gs.phase   <= tug_pkg::counting_down;
                        gs.cd_left <= tug_pkg::countdown_secs;
                    end
                tug_pkg::counting_down:
                    if (sec_tick)
                    begin
                        if (gs.cd_left == 2'd1)
                        begin
                            gs.phase    <= tug_pkg::gaming;
                            gs.sec_left <= sec_set;
                            rc.start    <= 1'b1;
                        end
                        else
                            gs.cd_left <= gs.cd_left - 2'd1;
                    end
                tug_pkg::gaming:
                    if (rc.done)
                    begin
                        gs.phase <= tug_pkg::check;
                        result   <= rc.winner;
                        scored   <= 1'b1;
                    end
                    else if (sec_tick && gs.sec_left != 7'd0)
                        gs.sec_left <= gs.sec_left - 7'd1;   // holds at zero
                tug_pkg::check:
                    if (scored)
                    begin
                        gs.round_no <= gs.round_no + 5'd1;
                        if (result == tug_pkg::p1)
                        begin
                            gs.score1  <= gs.score1 + 4'd1;
                            round_led1 <= 1'b1;
                        end
                        else if (result == tug_pkg::p2)
                        begin
                            gs.score2  <= gs.score2 + 4'd1;
                            round_led2 <= 1'b1;
                        end
                    end
                    else if (target_hit)
                    begin
                        gs.phase   <= tug_pkg::gameover;
                        match_led1 <= (gs.score1 == win_target);
                        match_led2 <= (gs.score2 == win_target);
                    end
                    else if (refer_pulse)
                    begin
                        gs.phase   <= tug_pkg::counting_down;
                        gs.cd_left <= tug_pkg::countdown_secs;
                        round_led1 <= 1'b0;
                        round_led2 <= 1'b0;
                    end
                tug_pkg::gameover:
                    gs.phase <= tug_pkg::gameover;    // until reset
            endcase
        end
    end

endmodule

// File: logic/match_setup.sv
module match_setup (
    input  logic            clk,
    input  logic            rst,
    input  logic            plus_pulse,
    input  logic            minus_pulse,
    input  tug_pkg::phase_t phase,
    output logic [6:0]      sec_set,
    output logic [3:0]      win_target
);

    logic up;
    logic down;

    // both keys together cancel
    assign up   = plus_pulse && !minus_pulse;
    assign down = minus_pulse && !plus_pulse;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sec_set    <= tug_pkg::sec_min;
            win_target <= 4'd1;
        end
        else if (phase == tug_pkg::time_set)
        begin
            if (up)
                sec_set <= (sec_set >= tug_pkg::sec_max) ? tug_pkg::sec_min
                                                         : sec_set + tug_pkg::sec_step;
            else if (down)
                sec_set <= (sec_set <= tug_pkg::sec_min) ? tug_pkg::sec_max
                                                         : sec_set - tug_pkg::sec_step;
        end
        else if (phase == tug_pkg::round_set)
        begin
            if (up)
                win_target <= (win_target >= tug_pkg::win_max) ? 4'd1 : win_target + 4'd1;
            else if (down)
                win_target <= (win_target <= 4'd1) ? tug_pkg::win_max : win_target - 4'd1;
        end
    end

endmodule

// File: logic/rope_if.sv
interface rope_if;

    logic             active;      // level, high in gaming
    logic             start;       // pulse on entry to gaming
    logic             time_up;
    logic             done;        // pulse, round decided
    tug_pkg::winner_t winner;

    modport ctrl (
        output active, start, time_up,
        input  done, winner
    );

    modport judge (
        input  active, start, time_up,
        output done, winner
    );

endinterface

// File: logic/rope_judge.sv
module rope_judge (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      player1_pulse,
    input  logic                      player2_pulse,
    rope_if.judge                     rj,
    output logic [tug_pkg::rope_w-1:0] rope
);

    localparam int rw  = tug_pkg::rope_w;
    localparam int mid = tug_pkg::rope_center;

    logic at_end;
    logic settled;     // result already reported this round
    logic move;
    logic judge_now;
    logic left_side;
    logic right_side;

    assign at_end     = rope[0] | rope[rw-1];
    assign left_side  = |rope[mid-1:0];
    assign right_side = |rope[rw-1:mid+1];

    // pulls stop once the rope is at an end or time is over
    assign move = rj.active && !settled && !at_end && !rj.time_up
                  && (player1_pulse ^ player2_pulse);
    assign judge_now = rj.active && !settled && (at_end || rj.time_up);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rope    <= '0;
            settled <= 1'b1;
            rj.done <= 1'b0;
        end
        else
        begin
            rj.done <= 1'b0;
            if (rj.start)
            begin
                rope    <= rw'(1) << mid;
                settled <= 1'b0;
            end
            else if (judge_now)
            begin
                rj.done <= 1'b1;
                settled <= 1'b1;
            end
            else if (move)
            begin
                if (player1_pulse)
                    rope <= rope >> 1;                 // toward lamp 0
                else
                    rope <= rope << 1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (judge_now)
        begin
            if (left_side)
                rj.winner <= tug_pkg::p1;
            else if (right_side)
                rj.winner <= tug_pkg::p2;
            else
                rj.winner <= tug_pkg::draw;            // still at centre
        end
    end

endmodule

// File: logic/seg_display.sv
module seg_display (
    input  logic       clk,
    input  logic       rst,
    game_if.sink       gd,
    output logic [7:0] segdata1,
    output logic [7:0] segdata0,
    output logic [7:0] seg,
    output logic [7:0] sel8
);

    logic [7:0][7:0] disp;     // digit 7 is leftmost
    logic [2:0]      scan;
    logic            scan_on;
    logic [3:0]      sec_set_tens;
    logic [3:0]      sec_set_units;
    logic [3:0]      sec_left_tens;
    logic [3:0]      sec_left_units;

    assign scan_on = (gd.phase >= tug_pkg::ready);

    assign sec_set_tens   = 4'(gd.sec_set / 7'd10);
    assign sec_set_units  = 4'(gd.sec_set % 7'd10);
    assign sec_left_tens  = 4'(gd.sec_left / 7'd10);
    assign sec_left_units = 4'(gd.sec_left % 7'd10);

    always_comb
    begin
        disp[7] = tug_pkg::seg_of_digit(gd.win_target);
        disp[6] = tug_pkg::seg_dash;
        disp[5] = tug_pkg::seg_of_digit(4'(gd.round_no / 5'd10));
        disp[4] = tug_pkg::seg_of_digit(4'(gd.round_no % 5'd10));
        disp[3] = tug_pkg::seg_of_digit(gd.score1);
        disp[2] = tug_pkg::seg_dash;
        disp[1] = tug_pkg::seg_dash;
        disp[0] = tug_pkg::seg_of_digit(gd.score2);
    end

    // two-digit display on the core board
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            segdata1 <= 8'h00;
            segdata0 <= 8'h00;
        end
        else
        begin
            case (gd.phase)
                tug_pkg::time_set, tug_pkg::ready:
                begin
                    segdata1 <= tug_pkg::seg_of_digit(sec_set_tens);
                    segdata0 <= tug_pkg::seg_of_digit(sec_set_units);
                end
                tug_pkg::round_set:
                    segdata1 <= tug_pkg::seg_of_digit(gd.win_target);
                tug_pkg::counting_down:
                    segdata0 <= tug_pkg::seg_of_digit({2'b00, gd.cd_left});
                tug_pkg::gaming:
                begin
                    segdata1 <= tug_pkg::seg_of_digit(sec_left_tens);
                    segdata0 <= tug_pkg::seg_of_digit(sec_left_units);
                end
                default: ;             // check and gameover keep the last value
            endcase
        end
    end

    // eight-digit scan, sel8 active low
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            scan <= 3'd0;
            sel8 <= 8'hff;
            seg  <= 8'h00;
        end
        else if (scan_on)
        begin
            scan <= scan + 3'd1;
            sel8 <= ~(8'b1 << scan);
            seg  <= disp[scan];
        end
        else
            sel8 <= 8'hff;
    end

endmodule

// File: logic/tug_pkg.sv
package tug_pkg;

    typedef enum logic [2:0] {
        init,
        time_set,
        round_set,
        ready,
        counting_down,
        gaming,
        check,
        gameover
    } phase_t;

    typedef enum logic [1:0] {
        none,
        p1,
        p2,
        draw
    } winner_t;

    localparam int rope_w      = 9;
    localparam int rope_center = 4;

    localparam logic [6:0] sec_step = 7'd5;
    localparam logic [6:0] sec_min  = 7'd5;
    localparam logic [6:0] sec_max  = 7'd95;
    localparam logic [3:0] win_max  = 4'd9;

    localparam logic [1:0] countdown_secs = 2'd3;

    localparam int def_clk_per_sec     = 12_000_000;   // 12 MHz board clock
    localparam int def_debounce_cycles = 240_000;      // about 20 ms

    localparam logic [7:0] seg_dash = 8'h40;

    function automatic logic [7:0] seg_of_digit(input logic [3:0] digit);
        case (digit)
            4'd0: return 8'h3f;
            4'd1: return 8'h06;
            4'd2: return 8'h5b;
            4'd3: return 8'h4f;
            4'd4: return 8'h66;
            4'd5: return 8'h6d;
            4'd6: return 8'h7d;
            4'd7: return 8'h07;
            4'd8: return 8'h7f;
            4'd9: return 8'h6f;
            default: return 8'h00;     // blank
        endcase
    endfunction

endpackage

// File: logic/tug_top.sv
module tug_top #(
    parameter int clk_per_sec     = tug_pkg::def_clk_per_sec,
    parameter int debounce_cycles = tug_pkg::def_debounce_cycles
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      set,
    input  logic                      plus,
    input  logic                      minus,
    input  logic                      refer,
    input  logic                      player1,
    input  logic                      player2,
    output logic [tug_pkg::rope_w-1:0] rope,
    output logic [7:0]                segdata1,
    output logic [7:0]                segdata0,
    output logic [7:0]                seg,
    output logic [7:0]                sel8,
    output logic                      round_led1,
    output logic                      round_led2,
    output logic                      match_led1,
    output logic                      match_led2
);

    logic [5:0] keys;
    logic [5:0] pulses;        // set, plus, minus, refer, player1, player2
    logic [6:0] sec_set;
    logic [3:0] win_target;

    game_if gi ();
    rope_if ri ();

    assign keys = {set, plus, minus, refer, player1, player2};

    for (genvar i = 0; i < 6; i++)
    begin : g_key
        key_debounce #(
            .debounce_cycles (debounce_cycles)
        ) u_key (
            .clk       (clk),
            .rst       (rst),
            .key       (keys[i]),
            .key_pulse (pulses[i])
        );
    end

    match_setup u_setup (
        .clk         (clk),
        .rst         (rst),
        .plus_pulse  (pulses[4]),
        .minus_pulse (pulses[3]),
        .phase       (gi.phase),
        .sec_set     (sec_set),
        .win_target  (win_target)
    );

    match_ctrl #(
        .clk_per_sec (clk_per_sec)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .set_pulse   (pulses[5]),
        .refer_pulse (pulses[2]),
        .sec_set     (sec_set),
        .win_target  (win_target),
        .rc          (ri.ctrl),
        .gs          (gi.src),
        .round_led1  (round_led1),
        .round_led2  (round_led2),
        .match_led1  (match_led1),
        .match_led2  (match_led2)
    );

    rope_judge u_judge (
        .clk           (clk),
        .rst           (rst),
        .player1_pulse (pulses[1]),
        .player2_pulse (pulses[0]),
        .rj            (ri.judge),
        .rope          (rope)
    );

    seg_display u_disp (
        .clk      (clk),
        .rst      (rst),
        .gd       (gi.sink),
        .segdata1 (segdata1),
        .segdata0 (segdata0),
        .seg      (seg),
        .sel8     (sel8)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile and run the tug-of-war testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tug_tb -Mdir obj_dir -o tug_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tug_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: src.f
logic/tug_pkg.sv
logic/game_if.sv
logic/rope_if.sv
logic/key_debounce.sv
logic/match_setup.sv
logic/rope_judge.sv
logic/match_ctrl.sv
logic/seg_display.sv
logic/tug_top.sv
verif/tug_tb.sv

// File: verif/tug_cases.txt
# name time_plus time_minus round_plus round_minus exp_sec exp_win n_rounds rounds... exp_score1 exp_score2
# round: pull string of 1 (player1) and 2 (player2) in random order, or wait for the time-out

# one press down from 5 s wraps to 95 s
single_round 0 1 0 0 95 1 1 1111 1 0

# 19 presses up wrap back to 5 s
time_plus_wrap 19 0 1 0 5 2 4 2222 wait 12111 222 1 2

# rounds wrap past 9 to 1, then up to 2
round_plus_wrap 2 1 10 0 10 2 2 1111 11112 2 0

# draws at centre, by waiting and by balanced pulls
draw_rounds 0 0 1 0 5 2 5 wait 1122 2222 1 22222 1 2

time_minus_wrap 0 18 0 8 10 2 2 21222 2222 0 2

late_pulls 1 0 2 0 10 3 4 221 2222 111111 2222 1 3

// File: verif/tug_tb.sv
module tug_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_per_sec      = 50;
    localparam int debounce_cycles  = 4;
    localparam int countdown_cycles = 3 * clk_per_sec;   // three-second start countdown
    localparam int center           = 4;
    localparam int last_lamp        = 8;

    localparam int k_set   = 0;
    localparam int k_plus  = 1;
    localparam int k_minus = 2;
    localparam int k_refer = 3;
    localparam int k_p1    = 4;
    localparam int k_p2    = 5;

    logic       clk;
    logic       rst;
    logic       set;
    logic       plus;
    logic       minus;
    logic       refer;
    logic       player1;
    logic       player2;
    logic [8:0] rope;
    logic [7:0] segdata1;
    logic [7:0] segdata0;
    logic [7:0] seg;
    logic [7:0] sel8;
    logic       round_led1;
    logic       round_led2;
    logic       match_led1;
    logic       match_led2;

    int    errors;
    int    timeouts;
    int    seed;
    string test_name;
    string plans[$];

    tug_top #(
        .clk_per_sec     (clk_per_sec),
        .debounce_cycles (debounce_cycles)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .set        (set),
        .plus       (plus),
        .minus      (minus),
        .refer      (refer),
        .player1    (player1),
        .player2    (player2),
        .rope       (rope),
        .segdata1   (segdata1),
        .segdata0   (segdata0),
        .seg        (seg),
        .sel8       (sel8),
        .round_led1 (round_led1),
        .round_led2 (round_led2),
        .match_led1 (match_led1),
        .match_led2 (match_led2)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // segment codes 0 to 9
    function automatic logic [7:0] seg_code(input int d);
        case (d)
            0: seg_code = 8'h3f;
            1: seg_code = 8'h06;
            2: seg_code = 8'h5b;
            3: seg_code = 8'h4f;
            4: seg_code = 8'h66;
            5: seg_code = 8'h6d;
            6: seg_code = 8'h7d;
            7: seg_code = 8'h07;
            8: seg_code = 8'h7f;
            9: seg_code = 8'h6f;
            default: seg_code = 8'h00;
        endcase
    endfunction

    function automatic string token_text(input logic [255:0] raw);
        string s;
        int    i;
        s = "";
        for (i = 31; i >= 0; i--)
            if (raw[8*i +: 8] != 8'h00)
                s = $sformatf("%s%c", s, raw[8*i +: 8]);
        return s;
    endfunction

    task automatic drive_key(input int k, input logic v);
        case (k)
            k_set:   set <= v;
            k_plus:  plus <= v;
            k_minus: minus <= v;
            k_refer: refer <= v;
            k_p1:    player1 <= v;
            k_p2:    player2 <= v;
            default: ;
        endcase
    endtask

    task automatic press_key(input int k);
        @(posedge clk);
        drive_key(k, 1'b1);
        repeat (10) @(posedge clk);
        drive_key(k, 1'b0);
        repeat (10) @(posedge clk);
    endtask

    task automatic apply_reset;
        int k;
        @(posedge clk);
        rst <= 1'b0;
        for (k = k_set; k <= k_p2; k++)
            drive_key(k, 1'b0);
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic check_value(input string item, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            errors++;
            $display("Error %s %s: expected %0h, actual %0h", test_name, item, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout in %s: %s", test_name, what);
    endtask

    // sample the scanned digit k when sel8 picks it
    task automatic read_digit(input int k, output logic [7:0] code, output bit ok);
        int n;
        ok = 1'b0;
        code = 8'h00;
        for (n = 0; n < 64 && !ok; n++)
        begin
            @(negedge clk);
            if (sel8 == ~(8'b1 << k))
            begin
                code = seg;
                ok = 1'b1;
            end
        end
        if (!ok)
            report_timeout($sformatf("digit %0d was never selected", k));
    endtask

    task automatic wait_round_end(input int exp_round, input int limit, output bit ok);
        int         n;
        bit         got;
        logic [7:0] tens;
        logic [7:0] units;
        ok = 1'b0;
        for (n = 0; n < limit && !ok; n++)
        begin
            read_digit(5, tens, got);
            if (!got)
                return;
            read_digit(4, units, got);
            if (!got)
                return;
            if (tens == seg_code(exp_round / 10) && units == seg_code(exp_round % 10))
                ok = 1'b1;
        end
        if (!ok)
            report_timeout("round number never advanced");
    endtask

    // countdown shows 1 last, then gaming loads the centre lamp
    task automatic wait_play_start(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 1000 && !ok; n++)
        begin
            @(negedge clk);
            if (segdata0 == seg_code(1))
                ok = 1'b1;
        end
        if (!ok)
        begin
            report_timeout("start countdown never reached its last second");
            return;
        end
        ok = 1'b0;
        for (n = 0; n < 1000 && !ok; n++)
        begin
            @(negedge clk);
            if (rope == 9'(1 << center) && segdata0 != seg_code(1))
                ok = 1'b1;
        end
        if (!ok)
            report_timeout("rope never returned to the centre lamp");
    endtask

    task automatic play_round(input string plan, output int winner, output bit ok);
        int n1;
        int n2;
        int pos;
        int i;
        int pick;
        n1 = 0;
        n2 = 0;
        winner = 0;
        if (plan != "wait")
            for (i = 0; i < plan.len(); i++)
                if (plan[i] == "1")
                    n1++;
                else if (plan[i] == "2")
                    n2++;
        press_key(k_refer);
        wait_play_start(ok);
        if (!ok)
            return;
        pos = center;
        while ((n1 > 0 || n2 > 0) && pos != 0 && pos != last_lamp)
        begin
            if (n1 > 0 && n2 > 0)
                pick = ($random(seed) & 1) ? 2 : 1;
            else
                pick = (n1 > 0) ? 1 : 2;
            if (pick == 1)
            begin
                press_key(k_p1);
                n1--;
                pos--;                         // toward lamp 0
            end
            else
            begin
                press_key(k_p2);
                n2--;
                pos++;
            end
            if (pos != 0 && pos != last_lamp)
            begin
                @(negedge clk);
                check_value("rope", 1 << pos, 32'(rope));
            end
        end
        if (pos < center)
            winner = 1;
        else if (pos > center)
            winner = 2;
    endtask

    task automatic run_case(input int tplus, input int tminus, input int rplus,
                            input int rminus, input int exp_sec, input int exp_win,
                            input int exp_s1, input int exp_s2);
        int         i;
        int         n;
        int         score1;
        int         score2;
        int         exp_round;
        int         winner;
        bit         ok;
        logic [7:0] code;
        logic [8:0] held_rope;
        apply_reset;
        repeat (tplus) press_key(k_plus);
        repeat (tminus) press_key(k_minus);
        @(negedge clk);
        check_value("seconds tens", 32'(seg_code(exp_sec / 10)), 32'(segdata1));
        check_value("seconds units", 32'(seg_code(exp_sec % 10)), 32'(segdata0));
        press_key(k_set);
        repeat (rplus) press_key(k_plus);
        repeat (rminus) press_key(k_minus);
        @(negedge clk);
        check_value("rounds to win", 32'(seg_code(exp_win)), 32'(segdata1));
        press_key(k_set);
        score1 = 0;
        score2 = 0;
        exp_round = 1;
        for (i = 0; i < plans.size() && score1 != exp_win && score2 != exp_win; i++)
        begin
            play_round(plans[i], winner, ok);
            if (!ok)
                return;
            exp_round++;
            if (winner == 1)
                score1++;
            else if (winner == 2)
                score2++;
            wait_round_end(exp_round, exp_sec * clk_per_sec / 8 + 100, ok);
            if (!ok)
                return;
            check_value("round lamp 1", 32'(winner == 1), 32'(round_led1));
            check_value("round lamp 2", 32'(winner == 2), 32'(round_led2));
            read_digit(3, code, ok);
            if (!ok)
                return;
            check_value("score1 digit", 32'(seg_code(score1)), 32'(code));
            read_digit(0, code, ok);
            if (!ok)
                return;
            check_value("score2 digit", 32'(seg_code(score2)), 32'(code));
        end
        if (score1 != exp_win && score2 != exp_win)
        begin
            errors++;
            $display("%s: the listed rounds ended before any player won the match", test_name);
            return;
        end
        ok = 1'b0;
        for (n = 0; n < 50 && !ok; n++)
        begin
            @(negedge clk);
            if (match_led1 || match_led2)
                ok = 1'b1;
        end
        if (!ok)
        begin
            report_timeout("no match lamp lit after the last round");
            return;
        end
        held_rope = rope;
        press_key(k_refer);
        repeat (countdown_cycles) @(posedge clk);   // longer than a start countdown
        press_key(k_p1);
        @(negedge clk);
        check_value("rope after player1", 32'(held_rope), 32'(rope));
        press_key(k_p2);
        @(negedge clk);
        check_value("rope after player2", 32'(held_rope), 32'(rope));
        check_value("match lamp 1", 32'(exp_s1 == exp_win), 32'(match_led1));
        check_value("match lamp 2", 32'(exp_s2 == exp_win), 32'(match_led2));
        read_digit(3, code, ok);
        if (!ok)
            return;
        check_value("final score1", 32'(seg_code(exp_s1)), 32'(code));
        read_digit(0, code, ok);
        if (!ok)
            return;
        check_value("final score2", 32'(seg_code(exp_s2)), 32'(code));
    endtask

    initial
    begin
        int             fd;
        int             code;
        int             i;
        int             cases_run;
        int             tplus;
        int             tminus;
        int             rplus;
        int             rminus;
        int             exp_sec;
        int             exp_win;
        int             n_rounds;
        int             exp_s1;
        int             exp_s2;
        logic [255:0]   tok;
        logic [1599:0]  line_buf;
        errors = 0;
        timeouts = 0;
        cases_run = 0;
        seed = 32'hed23_26b7;
        rst <= 1'b0;
        set <= 1'b0;
        plus <= 1'b0;
        minus <= 1'b0;
        refer <= 1'b0;
        player1 <= 1'b0;
        player2 <= 1'b0;
        fd = $fopen("verif/tug_cases.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the case file verif/tug_cases.txt");
        end
        else
        begin
            while (timeouts == 0)
            begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1)
                    break;
                test_name = token_text(tok);
                if (test_name[0] == "#")
                begin
                    code = $fgets(line_buf, fd);   // rest of a comment line
                    continue;
                end
                code = $fscanf(fd, "%d %d %d %d %d %d %d", tplus, tminus, rplus, rminus,
                               exp_sec, exp_win, n_rounds);
                plans.delete();
                for (i = 0; i < n_rounds; i++)
                begin
                    code = $fscanf(fd, "%s", tok);
                    plans.push_back(token_text(tok));
                end
                code = $fscanf(fd, "%d %d", exp_s1, exp_s2);
                run_case(tplus, tminus, rplus, rminus, exp_sec, exp_win, exp_s1, exp_s2);
                cases_run++;
            end
            $fclose(fd);
            if (cases_run == 0)
            begin
                errors++;
                $display("No test case was read from verif/tug_cases.txt");
            end
        end
        $display("cases run: %0d, errors: %0d, timeouts: %0d", cases_run, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
